//--- logic/ctl_pkg.sv
`default_nettype none

package ctl_pkg;

    // instruction word layout is op, d, a, b from the top bit down
    localparam int OPCODE_WIDTH  = 4;
    localparam int OPERAND_WIDTH = 8;
    localparam int INSTR_WIDTH   = OPCODE_WIDTH + (3 * OPERAND_WIDTH);

    // the PC addresses instruction memory directly
    localparam int I_ADDR_WIDTH  = 8;

    localparam int A_WORD_WIDTH  = 16;
    localparam int A_ADDR_WIDTH  = 8;

    typedef enum logic [OPCODE_WIDTH-1:0] {
        OP_NOP = 4'd0,
        OP_ADD = 4'd1,
        OP_JMP = 4'd2,
        OP_JZ  = 4'd3,
        OP_JNZ = 4'd4,
        OP_IWR = 4'd5
    } op_e;

    // an all-zero word decodes as a NOP, which the annul mask relies on
    typedef struct packed {
        op_e                      op;
        logic [OPERAND_WIDTH-1:0] d;
        logic [OPERAND_WIDTH-1:0] a;
        logic [OPERAND_WIDTH-1:0] b;
    } instr_t;

    typedef struct packed {
        logic                    en;
        op_e                     op;
        logic [I_ADDR_WIDTH-1:0] addr;
        instr_t                  data;
    } imem_wr_t;

    typedef struct packed {
        logic                    en;
        logic [A_ADDR_WIDTH-1:0] addr;
        logic [A_WORD_WIDTH-1:0] data;
    } amem_wr_t;

endpackage

`default_nettype wire

//--- logic/sdp_ram.sv
`default_nettype none

// simple dual-port RAM, one write port and one registered read port
module sdp_ram #(
    parameter int WORD_WIDTH = 8,
    parameter int ADDR_WIDTH = 8
) (
    input  logic                  clock,
    input  logic                  wren,
    input  logic [ADDR_WIDTH-1:0] write_addr,
    input  logic [WORD_WIDTH-1:0] write_data,
    input  logic [ADDR_WIDTH-1:0] read_addr,
    output logic [WORD_WIDTH-1:0] read_data
);

    localparam int WORD_COUNT = 2 ** ADDR_WIDTH;

    logic [WORD_WIDTH-1:0] mem [WORD_COUNT];

    always_ff @(posedge clock) begin
        if (wren) begin
            mem[write_addr] <= write_data;
        end
    end

    // read data appears one cycle after the address is presented
    // a read of the address being written returns the old word
    always_ff @(posedge clock) begin
        read_data <= mem[read_addr];
    end

endmodule

`default_nettype wire

//--- logic/delay_line.sv
`default_nettype none

// chain of DEPTH registers used to retime signals between pipeline stages
module delay_line #(
    parameter int DEPTH = 1,
    parameter int WIDTH = 1
) (
    input  logic             clock,
    input  logic             arst_n,
    input  logic [WIDTH-1:0] in_data,
    output logic [WIDTH-1:0] out_data
);

    generate
        if (DEPTH == 0) begin : g_pass
            // no stages, the signal is used in the same cycle
            assign out_data = in_data;
        end else begin : g_stages
            logic [WIDTH-1:0] stage [DEPTH];

            always_ff @(posedge clock or negedge arst_n) begin
                if (!arst_n) begin
                    for (int i = 0; i < DEPTH; i++) begin
                        stage[i] <= '0;
                    end
                end else begin
                    stage[0] <= in_data;
                    for (int i = 1; i < DEPTH; i++) begin
                        stage[i] <= stage[i-1];
                    end
                end
            end

            assign out_data = stage[DEPTH-1];
        end
    endgenerate

endmodule

`default_nettype wire

//--- logic/pc_controller.sv
`default_nettype none

// per-thread program counters with jump resolution
// one thread is served per clock, in a fixed rotation
module pc_controller #(
    parameter int THREAD_COUNT      = 8,
    parameter int THREAD_ADDR_WIDTH = 3
) (
    input  logic                                clock,
    input  logic                                arst_n,
    input  ctl_pkg::instr_t                     instr,
    input  logic [ctl_pkg::A_WORD_WIDTH-1:0]    a_data,
    input  logic                                io_ready,
    output logic [ctl_pkg::I_ADDR_WIDTH-1:0]    pc,
    output logic [THREAD_ADDR_WIDTH-1:0]        thread
);

    localparam logic [THREAD_ADDR_WIDTH-1:0] LAST_THREAD =
        THREAD_ADDR_WIDTH'(THREAD_COUNT - 1);

    logic [ctl_pkg::I_ADDR_WIDTH-1:0] pc_store [THREAD_COUNT];
    logic [ctl_pkg::I_ADDR_WIDTH-1:0] cur_pc;
    logic [ctl_pkg::I_ADDR_WIDTH-1:0] next_pc;
    logic                             a_zero;
    logic                             take_jump;

    // the loop latency equals THREAD_COUNT, so the instruction arriving now
    // was fetched from the PC stored for the thread being served now
    assign cur_pc = pc_store[thread];
    assign a_zero = (a_data == '0);

    always_comb begin
        case (instr.op)
            ctl_pkg::OP_JMP: take_jump = 1'b1;
            ctl_pkg::OP_JZ:  take_jump = a_zero;
            ctl_pkg::OP_JNZ: take_jump = !a_zero;
            default:         take_jump = 1'b0;
        endcase
    end

    // an annulled instruction holds the PC so the same address is refetched
    always_comb begin
        if (!io_ready) begin
            next_pc = cur_pc;
        end else if (take_jump) begin
            next_pc = instr.d;
        end else begin
            next_pc = cur_pc + 1'b1;
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            thread <= '0;
        end else if (thread == LAST_THREAD) begin
            thread <= '0;
        end else begin
            thread <= thread + 1'b1;
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < THREAD_COUNT; i++) begin
                pc_store[i] <= '0;
            end
            pc <= '0;
        end else begin
            pc_store[thread] <= next_pc;
            pc               <= next_pc;
        end
    end

endmodule

`default_nettype wire

//--- logic/control_path.sv
`default_nettype none

// fetch, retiming, I/O annul and PC control for the barrel pipeline
module control_path #(
    parameter int THREAD_COUNT      = 8,
    parameter int THREAD_ADDR_WIDTH = 3,
    parameter int I_TAP_DEPTH       = 1,
    parameter int TAP_AB_DEPTH      = 2,
    parameter int AB_READ_DEPTH     = 1,
    parameter int PC_DEPTH          = 2
) (
    input  logic                             clock,
    input  logic                             arst_n,
    input  ctl_pkg::imem_wr_t                imem_wr,
    input  logic [ctl_pkg::A_WORD_WIDTH-1:0] a_data,
    input  logic                             io_ready,
    output ctl_pkg::instr_t                  instr,
    output logic [ctl_pkg::I_ADDR_WIDTH-1:0] pc
);

    logic                             imem_wren;
    ctl_pkg::instr_t                  instr_ram;
    ctl_pkg::instr_t                  instr_ab;
    ctl_pkg::instr_t                  instr_masked;
    ctl_pkg::instr_t                  instr_ctrl;
    logic                             io_ready_ctrl;
    logic [ctl_pkg::I_ADDR_WIDTH-1:0] ctrl_pc;

    // only the instruction-write opcode may modify instruction memory
    assign imem_wren = imem_wr.en && (imem_wr.op == ctl_pkg::OP_IWR);

    sdp_ram #(
        .WORD_WIDTH (ctl_pkg::INSTR_WIDTH),
        .ADDR_WIDTH (ctl_pkg::I_ADDR_WIDTH)
    ) i_imem (
        .clock      (clock),
        .wren       (imem_wren),
        .write_addr (imem_wr.addr),
        .write_data (imem_wr.data),
        .read_addr  (pc),
        .read_data  (instr_ram)
    );

    // the tap stage is what the rest of the core sees as the current instruction
    delay_line #(
        .DEPTH (I_TAP_DEPTH),
        .WIDTH (ctl_pkg::INSTR_WIDTH)
    ) i_tap_line (
        .clock    (clock),
        .arst_n   (arst_n),
        .in_data  (instr_ram),
        .out_data (instr)
    );

    delay_line #(
        .DEPTH (TAP_AB_DEPTH),
        .WIDTH (ctl_pkg::INSTR_WIDTH)
    ) i_ab_line (
        .clock    (clock),
        .arst_n   (arst_n),
        .in_data  (instr),
        .out_data (instr_ab)
    );

    // when the I/O side is not ready the instruction becomes all zeros, a NOP
    assign instr_masked = io_ready ? instr_ab : '0;

    delay_line #(
        .DEPTH (AB_READ_DEPTH),
        .WIDTH (ctl_pkg::INSTR_WIDTH)
    ) i_read_line (
        .clock    (clock),
        .arst_n   (arst_n),
        .in_data  (instr_masked),
        .out_data (instr_ctrl)
    );

    // io_ready follows its instruction so the controller knows to hold the PC
    delay_line #(
        .DEPTH (AB_READ_DEPTH),
        .WIDTH (1)
    ) i_ready_line (
        .clock    (clock),
        .arst_n   (arst_n),
        .in_data  (io_ready),
        .out_data (io_ready_ctrl)
    );

    pc_controller #(
        .THREAD_COUNT      (THREAD_COUNT),
        .THREAD_ADDR_WIDTH (THREAD_ADDR_WIDTH)
    ) i_pc_controller (
        .clock    (clock),
        .arst_n   (arst_n),
        .instr    (instr_ctrl),
        .a_data   (a_data),
        .io_ready (io_ready_ctrl),
        .pc       (ctrl_pc),
        .thread   ()
    );

    delay_line #(
        .DEPTH (PC_DEPTH),
        .WIDTH (ctl_pkg::I_ADDR_WIDTH)
    ) i_pc_line (
        .clock    (clock),
        .arst_n   (arst_n),
        .in_data  (ctrl_pc),
        .out_data (pc)
    );

endmodule

`default_nettype wire

//--- logic/barrel_core.sv
`default_nettype none

// top level of the barrel core, control path plus the A operand memory
module barrel_core #(
    parameter int THREAD_COUNT      = 8,
    parameter int THREAD_ADDR_WIDTH = 3,
    parameter int I_TAP_DEPTH       = 1,
    parameter int TAP_AB_DEPTH      = 2,
    parameter int AB_READ_DEPTH     = 1,
    parameter int PC_DEPTH          = 2
) (
    input  logic                             clock,
    input  logic                             arst_n,
    input  ctl_pkg::imem_wr_t                imem_wr,
    input  ctl_pkg::amem_wr_t                amem_wr,
    input  logic                             io_ready,
    output ctl_pkg::instr_t                  instr,
    output logic [ctl_pkg::I_ADDR_WIDTH-1:0] pc
);

    // the RAM read takes one of the cycles between tap and controller
    localparam int A_ALIGN_DEPTH = TAP_AB_DEPTH + AB_READ_DEPTH - 1;

    logic [ctl_pkg::A_WORD_WIDTH-1:0] a_read_data;
    logic [ctl_pkg::A_WORD_WIDTH-1:0] a_data_ctrl;

    control_path #(
        .THREAD_COUNT      (THREAD_COUNT),
        .THREAD_ADDR_WIDTH (THREAD_ADDR_WIDTH),
        .I_TAP_DEPTH       (I_TAP_DEPTH),
        .TAP_AB_DEPTH      (TAP_AB_DEPTH),
        .AB_READ_DEPTH     (AB_READ_DEPTH),
        .PC_DEPTH          (PC_DEPTH)
    ) i_control_path (
        .clock    (clock),
        .arst_n   (arst_n),
        .imem_wr  (imem_wr),
        .a_data   (a_data_ctrl),
        .io_ready (io_ready),
        .instr    (instr),
        .pc       (pc)
    );

    // A memory is addressed by the a field of the instruction at the tap stage
    sdp_ram #(
        .WORD_WIDTH (ctl_pkg::A_WORD_WIDTH),
        .ADDR_WIDTH (ctl_pkg::A_ADDR_WIDTH)
    ) i_amem (
        .clock      (clock),
        .wren       (amem_wr.en),
        .write_addr (amem_wr.addr),
        .write_data (amem_wr.data),
        .read_addr  (instr.a),
        .read_data  (a_read_data)
    );

    delay_line #(
        .DEPTH (A_ALIGN_DEPTH),
        .WIDTH (ctl_pkg::A_WORD_WIDTH)
    ) i_a_align_line (
        .clock    (clock),
        .arst_n   (arst_n),
        .in_data  (a_read_data),
        .out_data (a_data_ctrl)
    );

endmodule

`default_nettype wire

//--- sim/tb_clock_gen.sv
`default_nettype none

// free-running clock and an active-low reset released a little after an edge
module tb_clock_gen #(
    parameter int PERIOD       = 40,
    parameter int RESET_CYCLES = 5
) (
    output logic clock,
    output logic arst_n
);

    initial begin
        clock = 1'b0;
        forever #(PERIOD / 2) clock = ~clock;
    end

    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        #2 arst_n = 1'b1;
    end

endmodule

`default_nettype wire

//--- sim/tb_barrel_core.sv
`default_nettype none

module tb_barrel_core;

    localparam int LOAD_WORDS   = 256;
    localparam int LOAD_SETTLE  = 6;
    localparam int RUN_CYCLES   = 400;
    localparam int ANNUL_CYCLES = 400;
    localparam int GATE_CYCLES  = 320;
    localparam int CYCLE_LIMIT  = LOAD_WORDS + LOAD_SETTLE + RUN_CYCLES + ANNUL_CYCLES
                                  + GATE_CYCLES + 100;

    logic                             clock;
    logic                             arst_n;
    ctl_pkg::imem_wr_t                imem_wr;
    ctl_pkg::amem_wr_t                amem_wr;
    logic                             io_ready;
    ctl_pkg::instr_t                  instr;
    logic [ctl_pkg::I_ADDR_WIDTH-1:0] pc;

    // program and A memory contents, plus the model's view of instruction memory
    ctl_pkg::instr_t                  prog [256];
    logic [ctl_pkg::A_WORD_WIDTH-1:0] model_amem [256];
    ctl_pkg::instr_t                  model_imem [256];

    // short histories indexed by cycle modulo 16
    logic [7:0]      exp_hist [16];
    ctl_pkg::instr_t fetch_hist [16];
    logic            ready_hist [16];

    ctl_pkg::imem_wr_t pending_wr;
    int                cyc = -1;
    int                errors = 0;
    int                tests_failed = 0;
    int                test_start_errors;
    logic              pc_check = 1'b0;
    logic              instr_check = 1'b0;
    logic              annul_check = 1'b0;
    logic [7:0]        exp_pc = '0;
    logic [7:0]        held_pc = '0;
    ctl_pkg::instr_t   exp_instr = '0;

    tb_clock_gen #(.PERIOD(40), .RESET_CYCLES(5)) i_clock_gen (
        .clock  (clock),
        .arst_n (arst_n)
    );

    barrel_core i_dut (
        .clock    (clock),
        .arst_n   (arst_n),
        .imem_wr  (imem_wr),
        .amem_wr  (amem_wr),
        .io_ready (io_ready),
        .instr    (instr),
        .pc       (pc)
    );

    function automatic ctl_pkg::instr_t make_instr(input ctl_pkg::op_e op,
                                                   input logic [7:0] d,
                                                   input logic [7:0] a,
                                                   input logic [7:0] b);
        ctl_pkg::instr_t w;
        w.op = op;
        w.d  = d;
        w.a  = a;
        w.b  = b;
        return w;
    endfunction

    // next PC of a thread from the instruction it fetched and the ready level at annul
    function automatic logic [7:0] predict_pc(input logic [7:0] cur,
                                              input ctl_pkg::instr_t ins,
                                              input logic ready);
        logic a_zero;
        logic jump;
        a_zero = (model_amem[ins.a] == '0);
        jump   = (ins.op == ctl_pkg::OP_JMP) ||
                 (ins.op == ctl_pkg::OP_JZ && a_zero) ||
                 (ins.op == ctl_pkg::OP_JNZ && !a_zero);
        if (!ready) begin
            return cur;
        end else if (jump) begin
            return ins.d;
        end
        return 8'(cur + 8'd1);
    endfunction

    function automatic int slot(input int k);
        return (k + 16) % 16;
    endfunction

    task automatic next_cycle();
        @(posedge clock);
        #2;
    endtask

    task automatic end_test(input string name);
        int n;
        n = errors - test_start_errors;
        if (n == 0) begin
            $display("test %s: PASS", name);
        end else begin
            $display("test %s: FAIL with %0d errors", name, n);
            tests_failed++;
        end
        test_start_errors = errors;
    endtask

    always @(posedge clock) begin
        if (arst_n) begin
            cyc <= cyc + 1;
        end
    end

    // the loop is 8 cycles long, so pc(k) follows from pc(k-8), the word fetched
    // at edge k-7 and io_ready at the annul point in cycle k-4
    always @(negedge clock) begin
        if (arst_n && cyc >= 0) begin
            fetch_hist[slot(cyc)] = model_imem[exp_hist[slot(cyc - 1)]];
            if (pending_wr.en && pending_wr.op == ctl_pkg::OP_IWR) begin
                model_imem[pending_wr.addr] = pending_wr.data;
            end
            pending_wr = imem_wr;
            ready_hist[slot(cyc)] = io_ready;
            if (cyc < 10) begin
                exp_pc = '0;
                annul_check = 1'b0;
            end else begin
                exp_pc = predict_pc(exp_hist[slot(cyc - 8)], fetch_hist[slot(cyc - 7)],
                                    ready_hist[slot(cyc - 4)]);
                annul_check = !ready_hist[slot(cyc - 4)];
                held_pc = exp_hist[slot(cyc - 8)];
            end
            exp_hist[slot(cyc)] = exp_pc;
            exp_instr = fetch_hist[slot(cyc - 1)];
            pc_check = 1'b1;
            instr_check = (cyc >= 3);
        end
    end

    a_pc: assert property (@(posedge clock) disable iff (!arst_n)
        !pc_check || annul_check || pc == exp_pc)
    else begin
        errors++;
        $display("Mismatch at %0t: pc expected %0d, got %0d",
                 $time, $sampled(exp_pc), $sampled(pc));
    end

    a_instr: assert property (@(posedge clock) disable iff (!arst_n)
        !instr_check || instr == exp_instr)
    else begin
        errors++;
        $display("Mismatch at %0t: instr expected %h, got %h",
                 $time, $sampled(exp_instr), $sampled(instr));
    end

    a_annul_hold: assert property (@(posedge clock) disable iff (!arst_n)
        !annul_check || pc == held_pc)
    else begin
        errors++;
        $display("Mismatch at %0t: pc after annul expected %0d, got %0d",
                 $time, $sampled(held_pc), $sampled(pc));
    end

    always @(posedge clock) begin
        if (cyc > CYCLE_LIMIT) begin
            $display("timeout: the run went past %0d cycles", CYCLE_LIMIT);
            $display("Test failures found");
            $finish;
        end
    end

    initial begin
        imem_wr    = '0;
        amem_wr    = '0;
        io_ready   = 1'b0;
        pending_wr = '0;
        test_start_errors = 0;
        void'($urandom(68929));
        for (int i = 0; i < 16; i++) begin
            exp_hist[i]   = '0;
            fetch_hist[i] = '0;
            ready_hist[i] = 1'b0;
        end
        for (int i = 0; i < 256; i++) begin
            prog[i] = make_instr(i[0] ? ctl_pkg::OP_ADD : ctl_pkg::OP_NOP,
                                 8'(i ^ 'h5a), 8'(i), 8'(~i));
            model_imem[i] = '0;
            model_amem[i] = 16'($urandom);
        end
        prog[0]   = make_instr(ctl_pkg::OP_JMP, 8'd10, 8'd0, 8'd0);
        prog[10]  = make_instr(ctl_pkg::OP_JZ, 8'd20, 8'd1, 8'd0);
        prog[20]  = make_instr(ctl_pkg::OP_JZ, 8'd99, 8'd2, 8'd0);
        prog[21]  = make_instr(ctl_pkg::OP_JNZ, 8'd30, 8'd2, 8'd0);
        prog[30]  = make_instr(ctl_pkg::OP_JNZ, 8'd99, 8'd1, 8'd0);
        prog[31]  = make_instr(ctl_pkg::OP_JZ, 8'd200, 8'd3, 8'd0);
        prog[32]  = make_instr(ctl_pkg::OP_JMP, 8'd200, 8'd0, 8'd0);
        prog[200] = make_instr(ctl_pkg::OP_ADD, 8'd7, 8'd9, 8'd0);
        prog[201] = make_instr(ctl_pkg::OP_JMP, 8'd250, 8'd0, 8'd0);
        // word 1 is zero and word 2 non-zero, word 3 goes either way
        model_amem[1] = '0;
        model_amem[2] = 16'($urandom) | 16'd1;
        model_amem[3] = ($urandom % 2 == 0) ? '0 : 16'($urandom);

        // io_ready stays low while loading, so every thread holds PC 0
        wait (arst_n === 1'b1);
        for (int j = 0; j < LOAD_WORDS; j++) begin
            next_cycle();
            imem_wr.en   = 1'b1;
            imem_wr.op   = ctl_pkg::OP_IWR;
            imem_wr.addr = 8'(j);
            imem_wr.data = prog[j];
            amem_wr.en   = 1'b1;
            amem_wr.addr = 8'(j);
            amem_wr.data = model_amem[j];
        end
        next_cycle();
        imem_wr = '0;
        amem_wr = '0;
        repeat (LOAD_SETTLE) next_cycle();
        end_test("reset and load");

        io_ready = 1'b1;
        repeat (RUN_CYCLES) next_cycle();
        end_test("advance and jumps");

        for (int j = 0; j < ANNUL_CYCLES; j++) begin
            next_cycle();
            io_ready = ($urandom % 4) != 0;
        end
        next_cycle();
        io_ready = 1'b1;
        end_test("annul on io_ready");

        // a write with the wrong opcode must not reach the RAM
        repeat (40) next_cycle();
        imem_wr.en   = 1'b1;
        imem_wr.op   = ctl_pkg::OP_ADD;
        imem_wr.addr = 8'd200;
        imem_wr.data = make_instr(ctl_pkg::OP_JMP, 8'd240, 8'd0, 8'd0);
        next_cycle();
        imem_wr = '0;
        repeat (120) next_cycle();
        imem_wr.en   = 1'b1;
        imem_wr.op   = ctl_pkg::OP_IWR;
        imem_wr.addr = 8'd201;
        imem_wr.data = make_instr(ctl_pkg::OP_JMP, 8'd240, 8'd0, 8'd0);
        next_cycle();
        imem_wr = '0;
        repeat (GATE_CYCLES - 162) next_cycle();
        end_test("write gating");

        $display("tests run: 4, passed: %0d, failed: %0d, errors: %0d",
                 4 - tests_failed, tests_failed, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
logic/ctl_pkg.sv
logic/sdp_ram.sv
logic/delay_line.sv
logic/pc_controller.sv
logic/control_path.sv
logic/barrel_core.sv
sim/tb_clock_gen.sv
sim/tb_barrel_core.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the barrel core testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal \
    -f all.f --top-module tb_barrel_core -o tb_sim \
    && ./obj_dir/tb_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "All tests passed!" sim.log \
    && echo "simulation: PASS" \
    || { echo "simulation: FAIL"; exit 1; }
